// File: zx_pager.f
hw/zx_pager_pkg.sv
hw/zbus_decode.sv
hw/port_regs.sv
hw/dos_ctrl.sv
hw/mem_map.sv
hw/zx_pager_top.sv
dv/tb_zx_pager.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 \
	--top-module tb_zx_pager \
	-Mdir obj_dir \
	-o Vtb_zx_pager \
	-f zx_pager.f

./obj_dir/Vtb_zx_pager > "$LOG" 2>&1 || { cat "$LOG"; exit 1; }
cat "$LOG"

if grep -qF "*** TEST FAILED ***" "$LOG"; then
	echo "simulation reported a failure, see $LOG"
	exit 1
fi

echo "simulation finished without failures"

// File: dv/pager_input.txt
# T name | W addr data | S screen | R/M addr rom page offset dos (M is an M1 fetch)
# B addr rom page offset addr rom page offset (two back-to-back reads), all hex
T reset_map
R 0123 1 00 0123 0
R 4567 0 05 0567 0
R 9ABC 0 02 1ABC 0
R C001 0 00 0001 0
R 3FFF 1 00 3FFF 0
S 0
T port_7ffd
W 7FFD 1B
S 1
R C100 0 03 0100 0
R 0200 1 02 0200 0
W 7FFD 07
S 0
R FFFF 0 07 3FFF 0
R 0000 1 00 0000 0
W 7FFD 34
R C000 0 04 0000 0
R 1234 1 02 1234 0
W 7FFD 0F
S 0
R C000 0 04 0000 0
R 0000 1 02 0000 0
T eff7_atm
W EFF7 08
R 0100 0 00 0100 0
R 4100 0 05 0100 0
W 37F7 FC
W 7FF7 F0
W BFF7 80
W F7F7 FE
R 8000 0 02 0000 0
W EFF7 04
R 0123 1 03 0123 0
R 4444 0 0F 0444 0
R 8765 0 7F 0765 0
R C3C3 1 01 03C3 0
W EFF7 00
R 0000 1 02 0000 0
T dos_trap
M 3D2F 1 02 3D2F 1
R 0010 1 03 0010 1
R 3D00 1 03 3D00 1
M 0000 1 03 0000 1
M 8000 0 02 0000 0
R 0010 1 02 0010 0
M 3C00 1 02 3C00 0
W EFF7 08
M 3D00 0 00 3D00 0
W EFF7 00
M 3DFF 1 02 3DFF 1
M 4000 0 05 0000 0
T back_to_back
B 0100 1 02 0100 C200 0 04 0200
B 5A5A 0 05 1A5A 9001 0 02 1001

// File: dv/tb_zx_pager.sv
`timescale 1ns/1ps

module tb_zx_pager;
	import zx_pager_pkg::*;

	localparam int RESET_CYCLES  = 8;
	localparam int HOLD_CYCLES   = 3;
	localparam int VALID_TIMEOUT = 10;
	localparam int PAIR_TIMEOUT  = 12;
	// sampling edge to mem_valid
	localparam int LATENCY       = 2;

	logic        fclk;
	logic        rst_n;
	logic        iorq_n;
	logic        mreq_n;
	logic        rd_n;
	logic        wr_n;
	logic        m1_n;
	logic [15:0] a;
	logic [7:0]  d;
	logic        mem_valid;
	mem_access_t mem_out;
	logic        dos;
	logic        screen;

	int          checks;
	int          errors;
	int          tests_done;
	string       test_name;
	bit          test_open;
	int          test_checks_at;
	int          test_errors_at;

	// last single access
	bit          got_valid;
	int          latency;
	mem_access_t seen;
	logic        dos_seen;

	// back-to-back reads
	int          pair_seen;
	int          pair_at [2];
	mem_access_t pair_out [2];

	zx_pager_top DUT (.fclk(fclk), .rst_n(rst_n), .iorq_n(iorq_n), .mreq_n(mreq_n),
	                  .rd_n(rd_n), .wr_n(wr_n), .m1_n(m1_n), .a(a), .d(d),
	                  .mem_valid(mem_valid), .mem_out(mem_out), .dos(dos), .screen(screen));

	initial
	begin
		fclk = 1'b0;
		forever #10 fclk = ~fclk;
	end

	//////////////////////////////
	// bus driving
	//////////////////////////////
	task automatic release_bus();
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
	endtask

	// all bus tasks start and end on a falling edge
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		a      = addr;
		d      = data;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		repeat (HOLD_CYCLES) @(negedge fclk);
		release_bus();
		@(negedge fclk);
	endtask

	task automatic mem_access(input logic [15:0] addr, input logic fetch);
		int k;
		bit released;
		got_valid = 1'b0;
		released  = 1'b0;
		a      = addr;
		mreq_n = 1'b0;
		rd_n   = 1'b0;
		m1_n   = !fetch;
		k = 0;
		while (!got_valid && k < VALID_TIMEOUT)
		begin
			@(negedge fclk);
			k++;
			if (k == HOLD_CYCLES)
			begin
				release_bus();
				released = 1'b1;
			end
			if (mem_valid === 1'b1)
			begin
				got_valid = 1'b1;
				latency   = k - 1;
				seen      = mem_out;
				dos_seen  = dos;
			end
		end
		while (!released)
		begin
			@(negedge fclk);
			k++;
			if (k >= HOLD_CYCLES)
			begin
				release_bus();
				released = 1'b1;
			end
		end
		@(negedge fclk);
	endtask

	// strobes low one cycle, high one cycle, low again
	task automatic read_pair(input logic [15:0] addr_a, input logic [15:0] addr_b);
		int k;
		pair_seen = 0;
		a      = addr_a;
		mreq_n = 1'b0;
		rd_n   = 1'b0;
		m1_n   = 1'b1;
		k = 0;
		while (pair_seen < 2 && k < PAIR_TIMEOUT)
		begin
			@(negedge fclk);
			k++;
			if (k == 1 || k == 3)
				release_bus();
			else if (k == 2)
			begin
				a      = addr_b;
				mreq_n = 1'b0;
				rd_n   = 1'b0;
			end
			if (mem_valid === 1'b1)
			begin
				pair_at[pair_seen]  = k;
				pair_out[pair_seen] = mem_out;
				pair_seen++;
			end
		end
		release_bus();
		@(negedge fclk);
	endtask

	//////////////////////////////
	// checking and reporting
	//////////////////////////////
	task automatic report_mismatch(input string sig, input logic [15:0] exp_v,
			input logic [15:0] act_v);
		$display("mismatch at %0t ns: %s expected %h got %h", $time, sig, exp_v, act_v);
		errors++;
	endtask

	task automatic check_access(input logic exp_rom, input logic [7:0] exp_page,
			input logic [13:0] exp_off, input logic exp_dos);
		checks++;
		if (!got_valid)
		begin
			$display("error at %0t ns: mem_valid did not rise within %0d cycles of access",
				$time, VALID_TIMEOUT);
			errors++;
		end
		else
		begin
			checks += 6;
			if (latency != LATENCY)
				report_mismatch("latency", 16'(LATENCY), 16'(latency));
			if (seen.rom !== exp_rom)
				report_mismatch("mem_out.rom", 16'(exp_rom), 16'(seen.rom));
			if (seen.page !== exp_page)
				report_mismatch("mem_out.page", 16'(exp_page), 16'(seen.page));
			if (seen.offset !== exp_off)
				report_mismatch("mem_out.offset", 16'(exp_off), 16'(seen.offset));
			if (seen.rnw !== 1'b1)
				report_mismatch("mem_out.rnw", 16'(1'b1), 16'(seen.rnw));
			if (dos_seen !== exp_dos)
				report_mismatch("dos", 16'(exp_dos), 16'(dos_seen));
		end
	endtask

	// start is the falling edge right after that read's sampling edge
	task automatic check_pair(input int idx, input int start, input logic exp_rom,
			input logic [7:0] exp_page, input logic [13:0] exp_off);
		checks++;
		if (pair_seen <= idx)
		begin
			$display("error at %0t ns: read %0d of the pair got no mem_valid", $time, idx);
			errors++;
		end
		else
		begin
			checks += 4;
			if (pair_at[idx] - start != LATENCY)
				report_mismatch("latency", 16'(LATENCY), 16'(pair_at[idx] - start));
			if (pair_out[idx].rom !== exp_rom)
				report_mismatch("mem_out.rom", 16'(exp_rom), 16'(pair_out[idx].rom));
			if (pair_out[idx].page !== exp_page)
				report_mismatch("mem_out.page", 16'(exp_page), 16'(pair_out[idx].page));
			if (pair_out[idx].offset !== exp_off)
				report_mismatch("mem_out.offset", 16'(exp_off), 16'(pair_out[idx].offset));
		end
	endtask

	task automatic finish_test();
		int n_checks;
		int n_errors;
		if (test_open)
		begin
			n_checks = checks - test_checks_at;
			n_errors = errors - test_errors_at;
			if (n_errors == 0)
				$display("test %s: ok, %0d checks", test_name, n_checks);
			else
				$display("test %s: %0d of %0d checks wrong", test_name, n_errors, n_checks);
			tests_done++;
		end
		test_open = 1'b0;
	endtask

	task automatic bad_line(input string line);
		$display("error: stimulus line not understood: %s", line);
		errors++;
	endtask

	//////////////////////////////
	// stimulus file
	//////////////////////////////
	task automatic run_line(input string line);
		logic [7:0]  op;
		string       name;
		logic [15:0] addr;
		logic [15:0] addr_b;
		logic [7:0]  data;
		logic        exp_rom;
		logic        exp_rom_b;
		logic [7:0]  exp_page;
		logic [7:0]  exp_page_b;
		logic [13:0] exp_off;
		logic [13:0] exp_off_b;
		logic        exp_dos;
		int          n;
		op = line.getc(0);
		case (op)
			"T":
			begin
				n = $sscanf(line, "T %s", name);
				finish_test();
				test_name      = (n == 1) ? name : "unnamed";
				test_open      = 1'b1;
				test_checks_at = checks;
				test_errors_at = errors;
			end
			"W":
			begin
				n = $sscanf(line, "W %h %h", addr, data);
				if (n != 2)
					bad_line(line);
				else
					io_write(addr, data);
			end
			"R", "M":
			begin
				if (op == "R")
					n = $sscanf(line, "R %h %h %h %h %h", addr, exp_rom, exp_page, exp_off, exp_dos);
				else
					n = $sscanf(line, "M %h %h %h %h %h", addr, exp_rom, exp_page, exp_off, exp_dos);
				if (n != 5)
					bad_line(line);
				else
				begin
					mem_access(addr, op == "M");
					check_access(exp_rom, exp_page, exp_off, exp_dos);
				end
			end
			"S":
			begin
				n = $sscanf(line, "S %h", exp_rom);
				if (n != 1)
					bad_line(line);
				else
				begin
					checks++;
					if (screen !== exp_rom)
						report_mismatch("screen", 16'(exp_rom), 16'(screen));
				end
			end
			"B":
			begin
				n = $sscanf(line, "B %h %h %h %h %h %h %h %h", addr, exp_rom, exp_page,
					exp_off, addr_b, exp_rom_b, exp_page_b, exp_off_b);
				if (n != 8)
					bad_line(line);
				else
				begin
					read_pair(addr, addr_b);
					check_pair(0, 1, exp_rom, exp_page, exp_off);
					check_pair(1, 3, exp_rom_b, exp_page_b, exp_off_b);
				end
			end
			// comments and blank lines
			"#", " ", 8'h0a, 8'h0d, 8'h00:
			begin
			end
			default:
				bad_line(line);
		endcase
	endtask

	initial
	begin
		int    fd;
		int    rc;
		string line;
		rst_n      = 1'b0;
		a          = '0;
		d          = '0;
		release_bus();
		checks     = 0;
		errors     = 0;
		tests_done = 0;
		test_open  = 1'b0;
		repeat (RESET_CYCLES) @(negedge fclk);
		rst_n = 1'b1;
		@(negedge fclk);

		fd = $fopen("dv/pager_input.txt", "r");
		if (fd == 0)
		begin
			$display("error: stimulus file dv/pager_input.txt cannot be opened");
			errors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				rc = $fgets(line, fd);
				if (rc > 0)
					run_line(line);
			end
			$fclose(fd);
		end
		finish_test();

		$display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: hw/zx_pager_top.sv
`timescale 1ns/1ps

module zx_pager_top (
	input  logic                      fclk,
	input  logic                      rst_n,
	input  logic                      iorq_n,
	input  logic                      mreq_n,
	input  logic                      rd_n,
	input  logic                      wr_n,
	input  logic                      m1_n,
	input  logic [15:0]               a,
	input  logic [7:0]                d,
	output logic                      mem_valid,
	output zx_pager_pkg::mem_access_t mem_out,
	output logic                      dos,
	output logic                      screen
);
	import zx_pager_pkg::*;

	port_wr_t port_wr;
	mem_cyc_t mem_cyc;
	win_map_t win_map;

	//////////////////////////////
	// decode
	//////////////////////////////
	zbus_decode u_decode (.fclk(fclk), .rst_n(rst_n), .iorq_n(iorq_n), .mreq_n(mreq_n),
	                      .rd_n(rd_n), .wr_n(wr_n), .m1_n(m1_n), .a(a), .d(d),
	                      .port_wr(port_wr), .mem_cyc(mem_cyc));

	//////////////////////////////
	// pager state
	//////////////////////////////
	port_regs u_regs (.fclk(fclk), .rst_n(rst_n), .port_wr(port_wr), .dos(dos),
	                  .win_map(win_map), .screen(screen));

	dos_ctrl u_dos (.fclk(fclk), .rst_n(rst_n), .mem_cyc(mem_cyc),
	                .win0_rom(win_map[0].rom), .dos(dos));

	// physical access out
	mem_map u_map (.fclk(fclk), .rst_n(rst_n), .mem_cyc(mem_cyc), .win_map(win_map),
	               .mem_valid(mem_valid), .mem_out(mem_out));

endmodule

// File: hw/mem_map.sv
`timescale 1ns/1ps

module mem_map (
	input  logic                      fclk,
	input  logic                      rst_n,
	input  zx_pager_pkg::mem_cyc_t    mem_cyc,
	input  zx_pager_pkg::win_map_t    win_map,
	output logic                      mem_valid,
	output zx_pager_pkg::mem_access_t mem_out
);
	import zx_pager_pkg::*;

	win_cfg_t    cfg;
	mem_access_t access;

	//////////////////////////////
	// window lookup
	//////////////////////////////
	assign cfg = win_map[mem_cyc.window];

	always_comb
	begin
		access.rom    = cfg.rom;
		access.page   = cfg.page;
		access.offset = mem_cyc.offset;
		access.rnw    = mem_cyc.rnw;
	end

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			mem_valid <= 1'b0;
		end
		else
		begin
			mem_valid <= mem_cyc.valid;
		end
	end

	// held until the next access
	always_ff @(posedge fclk)
	begin
		if (mem_cyc.valid)
		begin
			mem_out <= access;
		end
	end

endmodule

// File: hw/dos_ctrl.sv
`timescale 1ns/1ps

module dos_ctrl (
	input  logic                   fclk,
	input  logic                   rst_n,
	input  zx_pager_pkg::mem_cyc_t mem_cyc,
	input  logic                   win0_rom,
	output logic                   dos
);
	import zx_pager_pkg::*;

	logic m1_fetch;
	logic dos_on;
	logic dos_off;

	assign m1_fetch = mem_cyc.valid && mem_cyc.m1;

	// trap area 3Dxx, only while ROM is shown
	assign dos_on  = m1_fetch && mem_cyc.window == 2'd0 && win0_rom
	                 && mem_cyc.offset[13:8] == DOS_TRAP_HI;
	assign dos_off = m1_fetch && mem_cyc.window != 2'd0;

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			dos <= 1'b0;
		end
		else if (dos_off)
		begin
			dos <= 1'b0;
		end
		else if (dos_on)
		begin
			dos <= 1'b1;
		end
	end

endmodule

// File: hw/port_regs.sv
`timescale 1ns/1ps

module port_regs (
	input  logic                   fclk,
	input  logic                   rst_n,
	input  zx_pager_pkg::port_wr_t port_wr,
	input  logic                   dos,
	output zx_pager_pkg::win_map_t win_map,
	output logic                   screen
);
	import zx_pager_pkg::*;

	p7ffd_t   p7ffd_q;
	eff7_t    eff7_q;
	win_map_t atm_q;

	logic     wr_7ffd, wr_eff7, wr_atm;
	win_cfg_t atm_cfg;

	assign wr_7ffd = port_wr.valid && port_wr.kind == PK_7FFD;
	assign wr_eff7 = port_wr.valid && port_wr.kind == PK_EFF7;
	assign wr_atm  = port_wr.valid && port_wr.kind == PK_ATM;

	// ATM pager ports hold the page inverted
	assign atm_cfg.rom  = !port_wr.ram;
	assign atm_cfg.page = ~port_wr.data.page_n;

	//////////////////////////////
	// 7FFD and EFF7
	//////////////////////////////
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			p7ffd_q <= '0;
		end
		else if (wr_7ffd && !p7ffd_q.lock)
		begin
			p7ffd_q <= port_wr.data.p7ffd;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			eff7_q <= '0;
		end
		else if (wr_eff7)
		begin
			eff7_q <= port_wr.data.eff7;
		end
	end

	//////////////////////////////
	// ATM window registers
	//////////////////////////////
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			atm_q <= '0;
		end
		else if (wr_atm)
		begin
			atm_q[port_wr.window] <= atm_cfg;
		end
	end

	// effective map
	always_comb
	begin
		if (eff7_q.atm_en)
		begin
			win_map = atm_q;
		end
		else
		begin
			if (eff7_q.ram0)
			begin
				win_map[0].rom  = 1'b0;
				win_map[0].page = '0;
			end
			else
			begin
				win_map[0].rom  = 1'b1;
				win_map[0].page = {6'd0, p7ffd_q.rom_sel, dos};
			end
			win_map[1].rom  = 1'b0;
			win_map[1].page = CLASSIC_WIN1_PAGE;
			win_map[2].rom  = 1'b0;
			win_map[2].page = CLASSIC_WIN2_PAGE;
			win_map[3].rom  = 1'b0;
			win_map[3].page = {5'd0, p7ffd_q.bank};
		end
	end

	assign screen = p7ffd_q.screen;

endmodule

// File: hw/zbus_decode.sv
`timescale 1ns/1ps

module zbus_decode (
	input  logic                   fclk,
	input  logic                   rst_n,
	input  logic                   iorq_n,
	input  logic                   mreq_n,
	input  logic                   rd_n,
	input  logic                   wr_n,
	input  logic                   m1_n,
	input  logic [15:0]            a,
	input  logic [7:0]             d,
	output zx_pager_pkg::port_wr_t port_wr,
	output zx_pager_pkg::mem_cyc_t mem_cyc
);
	import zx_pager_pkg::*;

	// first stage, bus as sampled
	logic        io_cond_q, mem_cond_q;
	logic        io_cond_qq, mem_cond_qq;
	logic [15:0] a_q;
	logic [7:0]  d_q;
	logic        wr_n_q, m1_n_q;

	port_kind_t  io_kind;
	logic        io_hit;

	always_ff @(posedge fclk)
	begin
		a_q    <= a;
		d_q    <= d;
		wr_n_q <= wr_n;
		m1_n_q <= m1_n;
	end

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			io_cond_q   <= 1'b0;
			mem_cond_q  <= 1'b0;
			io_cond_qq  <= 1'b0;
			mem_cond_qq <= 1'b0;
		end
		else
		begin
			io_cond_q   <= !iorq_n && !wr_n;
			mem_cond_q  <= !mreq_n && (!rd_n || !wr_n);
			io_cond_qq  <= io_cond_q;
			mem_cond_qq <= mem_cond_q;
		end
	end

	//////////////////////////////
	// port classification
	//////////////////////////////
	always_comb
	begin
		io_kind = PK_7FFD;
		io_hit  = 1'b0;
		if (a_q == PORT_EFF7)
		begin
			io_kind = PK_EFF7;
			io_hit  = 1'b1;
		end
		else if (a_q[7:0] == ATM_PORT_LO && a_q[13:12] == 2'b11)
		begin
			io_kind = PK_ATM;
			io_hit  = 1'b1;
		end
		else if (!a_q[15] && !a_q[1])
			io_hit = 1'b1;
	end

	// pulses on onset of each condition
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			port_wr.valid <= 1'b0;
			mem_cyc.valid <= 1'b0;
		end
		else
		begin
			port_wr.valid <= io_cond_q && !io_cond_qq && io_hit;
			mem_cyc.valid <= mem_cond_q && !mem_cond_qq;
		end
	end

	always_ff @(posedge fclk)
	begin
		port_wr.kind   <= io_kind;
		port_wr.window <= a_q[15:14];
		port_wr.ram    <= a_q[11];
		port_wr.data   <= d_q;
		mem_cyc.window <= a_q[15:14];
		mem_cyc.offset <= a_q[13:0];
		mem_cyc.rnw    <= wr_n_q;
		mem_cyc.m1     <= !m1_n_q;
	end

endmodule

// File: hw/zx_pager_pkg.sv
package zx_pager_pkg;

	//////////////////////////////
	// port addresses and pages
	//////////////////////////////
	localparam logic [7:0]  ATM_PORT_LO       = 8'hF7;
	localparam logic [15:0] PORT_EFF7         = 16'hEFF7;
	// offset bits 13..8 of the trap area
	localparam logic [5:0]  DOS_TRAP_HI       = 6'h3D;
	localparam logic [7:0]  CLASSIC_WIN1_PAGE = 8'd5;
	localparam logic [7:0]  CLASSIC_WIN2_PAGE = 8'd2;
	localparam int          NUM_WIN           = 4;

	typedef logic [1:0]  win_idx_t;
	typedef logic [7:0]  page_t;
	typedef logic [13:0] offset_t;

	//////////////////////////////
	// port data views
	//////////////////////////////
	typedef struct packed {
		logic [1:0] spare;
		logic       lock;
		logic       rom_sel;
		logic       screen;
		logic [2:0] bank;
	} p7ffd_t;

	typedef struct packed {
		logic [3:0] spare_hi;
		logic       ram0;
		logic       atm_en;
		logic [1:0] spare_lo;
	} eff7_t;

	// one data byte, three meanings depending on the port
	typedef union packed {
		p7ffd_t p7ffd;
		eff7_t  eff7;
		page_t  page_n;
	} port_data_u;

	typedef enum logic [1:0] {
		PK_7FFD,
		PK_EFF7,
		PK_ATM
	} port_kind_t;

	//////////////////////////////
	// bus events and mapping
	//////////////////////////////
	typedef struct packed {
		logic       valid;
		port_kind_t kind;
		win_idx_t   window;
		logic       ram;
		port_data_u data;
	} port_wr_t;

	typedef struct packed {
		logic     valid;
		win_idx_t window;
		offset_t  offset;
		logic     rnw;
		logic     m1;
	} mem_cyc_t;

	typedef struct packed {
		logic  rom;
		page_t page;
	} win_cfg_t;

	typedef win_cfg_t [NUM_WIN-1:0] win_map_t;

	typedef struct packed {
		logic    rom;
		page_t   page;
		offset_t offset;
		logic    rnw;
	} mem_access_t;

endpackage
